// ==== common/ppu_pkg.sv ====
package ppu_pkg;

  // ========================================
  // Plain widths
  // ========================================

  // CPU side address and data
  typedef logic [15:0] bus_addr_t;
  typedef logic [7:0] byte_t;

  // Background colour index, before BGP
  typedef logic [1:0] color_idx_t;

  // Shade after BGP
  typedef logic [1:0] shade_t;

  // Dot position within a line, line number within a frame
  typedef logic [8:0] dot_t;
  typedef logic [7:0] line_t;

  // Encoding matches STAT bits 1:0
  typedef enum logic [1:0] {
    hblank   = 2'd0,
    vblank   = 2'd1,
    oam_scan = 2'd2,
    transfer = 2'd3
  } ppu_mode_t;

  // ========================================
  // Bundles
  // ========================================

  // Host-visible LCD registers, LY and STAT low bits live elsewhere
  typedef struct packed {
    byte_t      lcdc;
    logic [3:0] stat_en;  // STAT 6:3, LYC / mode 2 / mode 1 / mode 0 sources
    byte_t      scy;
    byte_t      scx;
    byte_t      lyc;
    byte_t      bgp;
    byte_t      wy;
    byte_t      wx;
  } ppu_regs_t;

  // One host bus cycle
  typedef struct packed {
    bus_addr_t addr;
    byte_t     wdata;
    logic      write_en;
    logic      read_en;
  } host_req_t;

  // One shaded pixel with its screen position
  typedef struct packed {
    line_t  x;
    line_t  y;
    shade_t shade;
  } pixel_t;

  // ========================================
  // Address map
  // ========================================

  localparam bus_addr_t vram_start = 16'h8000;
  localparam bus_addr_t vram_end = 16'h9FFF;
  localparam bus_addr_t oam_start = 16'hFE00;
  localparam bus_addr_t oam_end = 16'hFE9F;
  localparam bus_addr_t regs_start = 16'hFF40;
  localparam bus_addr_t regs_end = 16'hFF4B;

  localparam bus_addr_t lcdc_addr = 16'hFF40;
  localparam bus_addr_t stat_addr = 16'hFF41;
  localparam bus_addr_t scy_addr = 16'hFF42;
  localparam bus_addr_t scx_addr = 16'hFF43;
  localparam bus_addr_t ly_addr = 16'hFF44;
  localparam bus_addr_t lyc_addr = 16'hFF45;
  localparam bus_addr_t dma_addr = 16'hFF46;
  localparam bus_addr_t bgp_addr = 16'hFF47;
  localparam bus_addr_t wy_addr = 16'hFF4A;
  localparam bus_addr_t wx_addr = 16'hFF4B;

  localparam int vram_words = 8192;
  localparam int oam_words = 160;

endpackage

// ==== ppu/ppu_timing.sv ====
`timescale 1ns/1ps

module ppu_timing #(
  parameter int dots_per_line = 456,
  parameter int lines_per_frame = 154,
  parameter int screen_height = 144,
  parameter int mode2_len = 80
) (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::ppu_regs_t  regs,
  input  logic                line_done,
  output ppu_pkg::ppu_mode_t  mode,
  output ppu_pkg::line_t      ly,
  output ppu_pkg::dot_t       dot,
  output logic                flush,
  output logic                vblank_req,
  output logic                stat_req,
  output logic                lyc_match
);

  import ppu_pkg::*;

  // Geometry in counter widths
  localparam dot_t last_dot = dot_t'(dots_per_line - 1);
  localparam dot_t last_scan_dot = dot_t'(mode2_len - 1);
  localparam line_t last_line = line_t'(lines_per_frame - 1);
  localparam line_t last_visible = line_t'(screen_height - 1);

  // LCDC bit 7
  logic lcd_on;
  logic end_of_line;

  // Previous values for STAT edge detection
  line_t     ly_prev;
  ppu_mode_t mode_prev;

  assign lcd_on = regs.lcdc[7];
  assign end_of_line = (dot == last_dot);

  // ========================================
  // Dot and line counters
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= '0;
      ly         <= '0;
      vblank_req <= 1'b0;
    end else begin
      vblank_req <= 1'b0;
      if (!lcd_on) begin
        // Held at the top of the frame
        dot <= '0;
        ly  <= '0;
      end else if (end_of_line) begin
        dot <= '0;
        if (ly == last_line) begin
          ly <= '0;
        end else begin
          ly <= ly + 1'b1;
        end
        // Entering the first VBlank line
        if (ly == last_visible) begin
          vblank_req <= 1'b1;
        end
      end else begin
        dot <= dot + 1'b1;
      end
    end
  end

  // ========================================
  // Mode state machine
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode  <= oam_scan;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (!lcd_on) begin
        mode <= oam_scan;
      end else if (end_of_line) begin
        // Next line decides the mode
        if (ly == last_line) begin
          mode <= oam_scan;
        end else if (ly >= last_visible) begin
          mode <= vblank;
        end else begin
          mode <= oam_scan;
        end
      end else begin
        unique case (mode)
          oam_scan: begin
            // Fetcher and writer restart with the transfer
            if (dot == last_scan_dot) begin
              mode  <= transfer;
              flush <= 1'b1;
            end
          end
          transfer: begin
            if (line_done) begin
              mode <= hblank;
            end
          end
          // HBlank and VBlank only leave at end of line
          hblank: ;
          vblank: ;
        endcase
      end
    end
  end

  // ========================================
  // STAT sources
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stat_req  <= 1'b0;
      lyc_match <= 1'b0;
      ly_prev   <= '0;
      mode_prev <= oam_scan;
    end else begin
      stat_req  <= 1'b0;
      // Coincidence flag, one cycle behind LY
      lyc_match <= (ly == regs.lyc);
      ly_prev   <= ly;
      mode_prev <= mode;
      if (lcd_on) begin
        // LY reached LYC
        if (regs.stat_en[3] && ly != ly_prev && ly == regs.lyc) begin
          stat_req <= 1'b1;
        end
        // Mode entry sources
        if (mode != mode_prev) begin
          if (regs.stat_en[2] && mode == oam_scan) begin
            stat_req <= 1'b1;
          end
          if (regs.stat_en[1] && mode == vblank) begin
            stat_req <= 1'b1;
          end
          if (regs.stat_en[0] && mode == hblank) begin
            stat_req <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== ppu/ppu_mem_bus.sv ====
`timescale 1ns/1ps

module ppu_mem_bus (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::host_req_t  host,
  output ppu_pkg::byte_t      host_rdata,
  input  ppu_pkg::ppu_mode_t  mode,
  input  ppu_pkg::line_t      ly,
  input  logic                lyc_match,
  output ppu_pkg::ppu_regs_t  regs,
  input  ppu_pkg::bus_addr_t  fetch_addr,
  output ppu_pkg::byte_t      fetch_data
);

  import ppu_pkg::*;

  byte_t vram [vram_words];
  byte_t oam [oam_words];

  // Address range selects
  logic sel_vram;
  logic sel_oam;
  logic sel_regs;

  // Host loses VRAM to the fetcher during pixel transfer
  logic vram_locked;

  assign sel_vram = host.addr inside {[vram_start : vram_end]};
  assign sel_oam = host.addr inside {[oam_start : oam_end]};
  assign sel_regs = host.addr inside {[regs_start : regs_end]};
  assign vram_locked = (mode == transfer);

  // ========================================
  // Register file
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (host.write_en && sel_regs) begin
      case (host.addr)
        lcdc_addr: regs.lcdc <= host.wdata;
        // Only bits 6:3 are writable
        stat_addr: regs.stat_en <= host.wdata[6:3];
        scy_addr:  regs.scy <= host.wdata;
        scx_addr:  regs.scx <= host.wdata;
        // LY is read only
        ly_addr:   ;
        lyc_addr:  regs.lyc <= host.wdata;
        // No OAM DMA
        dma_addr:  ;
        bgp_addr:  regs.bgp <= host.wdata;
        wy_addr:   regs.wy <= host.wdata;
        wx_addr:   regs.wx <= host.wdata;
        default:   ;
      endcase
    end
  end

  // ========================================
  // VRAM and OAM writes
  // ========================================

  always_ff @(posedge clk) begin
    if (host.write_en) begin
      // Dropped while the fetcher owns VRAM
      if (sel_vram && !vram_locked) begin
        vram[host.addr[12:0]] <= host.wdata;
      end
      // OAM always open to the host
      if (sel_oam) begin
        oam[host.addr[7:0]] <= host.wdata;
      end
    end
  end

  // ========================================
  // Reads
  // ========================================

  // Fetcher port, never blocked
  assign fetch_data = vram[fetch_addr[12:0]];

  always_comb begin
    // Open bus unless selected and allowed
    host_rdata = 8'hFF;
    if (host.read_en) begin
      if (sel_vram && !vram_locked) begin
        host_rdata = vram[host.addr[12:0]];
      end else if (sel_oam) begin
        host_rdata = oam[host.addr[7:0]];
      end else if (sel_regs) begin
        case (host.addr)
          lcdc_addr: host_rdata = regs.lcdc;
          // Bit 7 reads as one
          stat_addr: host_rdata = {1'b1, regs.stat_en, lyc_match, mode};
          scy_addr:  host_rdata = regs.scy;
          scx_addr:  host_rdata = regs.scx;
          ly_addr:   host_rdata = ly;
          lyc_addr:  host_rdata = regs.lyc;
          bgp_addr:  host_rdata = regs.bgp;
          wy_addr:   host_rdata = regs.wy;
          wx_addr:   host_rdata = regs.wx;
          // DMA and unused slots
          default:   host_rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

// ==== ppu/bg_fetcher.sv ====
`timescale 1ns/1ps

module bg_fetcher (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_pkg::ppu_regs_t        regs,
  input  ppu_pkg::line_t            ly,
  input  logic                      flush,
  input  ppu_pkg::ppu_mode_t        mode,
  input  logic [4:0]                fifo_count,
  output ppu_pkg::bus_addr_t        fetch_addr,
  input  ppu_pkg::byte_t            fetch_data,
  output logic                      push,
  output ppu_pkg::color_idx_t [7:0] push_row
);

  import ppu_pkg::*;

  // Tile map bases, LCDC bit 3
  localparam bus_addr_t map_lo_base = 16'h9800;
  localparam bus_addr_t map_hi_base = 16'h9C00;
  // Tile data bases, LCDC bit 4
  localparam bus_addr_t data_unsigned_base = 16'h8000;
  localparam bus_addr_t data_signed_base = 16'h9000;

  typedef enum logic [1:0] {
    st_tile,
    st_low,
    st_high,
    st_push
  } fetch_state_t;

  fetch_state_t state;

  // Column within the 32-wide map
  logic [4:0] tile_col;
  byte_t      tile_num;
  byte_t      data_lo;
  byte_t      data_hi;

  // Background row and fetch addresses
  line_t     bg_y;
  bus_addr_t map_addr;
  bus_addr_t tile_base;
  bus_addr_t row_addr;

  // FIFO has room for a full row
  logic room;

  assign bg_y = ly + regs.scy;
  assign room = (fifo_count <= 5'd8);

  always_comb begin
    map_addr = (regs.lcdc[3] ? map_hi_base : map_lo_base) + bus_addr_t'({bg_y[7:3], tile_col});
    // Sixteen bytes per tile
    if (regs.lcdc[4]) begin
      tile_base = data_unsigned_base + {4'b0000, tile_num, 4'b0000};
    end else begin
      tile_base = data_signed_base + {{4{tile_num[7]}}, tile_num, 4'b0000};
    end
    // Two bytes per tile row
    row_addr = tile_base + {12'd0, bg_y[2:0], 1'b0};
  end

  always_comb begin
    unique case (state)
      st_low:  fetch_addr = row_addr;
      st_high: fetch_addr = {row_addr[15:1], 1'b1};
      default: fetch_addr = map_addr;
    endcase
  end

  assign push = (state == st_push) && room && (mode == transfer) && !flush;

  // Leftmost pixel from bit 7, high plane first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_row[i] = {data_hi[7-i], data_lo[7-i]};
    end
  end

  // ========================================
  // Fetch sequence
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_tile;
      tile_col <= '0;
    end else if (flush) begin
      // First tile of the line
      state    <= st_tile;
      tile_col <= regs.scx[7:3];
    end else if (mode == transfer) begin
      unique case (state)
        st_tile: state <= st_low;
        st_low:  state <= st_high;
        st_high: state <= st_push;
        st_push: begin
          // Waits here while the FIFO is too full
          if (room) begin
            state    <= st_tile;
            tile_col <= tile_col + 1'b1;
          end
        end
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    unique case (state)
      st_tile: tile_num <= fetch_data;
      st_low:  data_lo <= fetch_data;
      st_high: data_hi <= fetch_data;
      st_push: ;
    endcase
  end

endmodule

// ==== ppu/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      push,
  input  ppu_pkg::color_idx_t [7:0] push_row,
  input  logic                      pop,
  output ppu_pkg::color_idx_t       head,
  output logic [4:0]                count
);

  import ppu_pkg::*;

  color_idx_t mem [16];

  // Pointers wrap at sixteen
  logic [3:0] rd_ptr;
  logic [3:0] wr_ptr;

  assign head = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 4'd8;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop on the same edge
      count <= count + (push ? 5'd8 : 5'd0) - (pop ? 5'd1 : 5'd0);
    end
  end

  // Row append, leftmost pixel at the tail
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + 4'(i)] <= push_row[i];
      end
    end
  end

endmodule

// ==== ppu/line_writer.sv ====
`timescale 1ns/1ps

module line_writer #(
  parameter int screen_width = 160
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_mode_t   mode,
  input  ppu_pkg::ppu_regs_t   regs,
  input  ppu_pkg::line_t       ly,
  input  logic                 flush,
  input  ppu_pkg::color_idx_t  fifo_head,
  input  logic [4:0]           fifo_count,
  output logic                 pop,
  output logic                 pixel_valid,
  output ppu_pkg::pixel_t      pixel,
  output logic                 line_done
);

  import ppu_pkg::*;

  localparam line_t last_x = line_t'(screen_width - 1);

  // Fine scroll pixels still to drop
  logic [2:0] discard;
  line_t      x;
  // Line still in progress
  logic       active;
  // Popped pixel is kept
  logic       emit;

  assign pop = active && (mode == transfer) && (fifo_count != 5'd0) && !flush;
  assign emit = pop && (discard == 3'd0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      discard     <= '0;
      x           <= '0;
      active      <= 1'b0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
      if (flush) begin
        // New line, SCX mod 8
        discard <= regs.scx[2:0];
        x       <= '0;
        active  <= 1'b1;
      end else if (pop) begin
        if (discard != 3'd0) begin
          discard <= discard - 1'b1;
        end else begin
          pixel_valid <= 1'b1;
          x           <= x + 1'b1;
          // Last pixel of the line
          if (x == last_x) begin
            active    <= 1'b0;
            line_done <= 1'b1;
          end
        end
      end
    end
  end

  // Index n picks BGP bits 2n+1:2n
  always_ff @(posedge clk) begin
    if (emit) begin
      pixel.x     <= x;
      pixel.y     <= ly;
      pixel.shade <= regs.bgp[{fifo_head, 1'b0} +: 2];
    end
  end

endmodule

// ==== src/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top #(
  parameter int dots_per_line = 456,
  parameter int lines_per_frame = 154,
  parameter int screen_height = 144,
  parameter int screen_width = 160,
  parameter int mode2_len = 80
) (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::host_req_t host,
  output ppu_pkg::byte_t     host_rdata,
  output logic               pixel_valid,
  output ppu_pkg::pixel_t    pixel,
  output logic               vblank_req,
  output logic               stat_req
);

  import ppu_pkg::*;

  // Timing outputs
  ppu_mode_t mode;
  line_t     ly;
  logic      flush;
  logic      lyc_match;
  logic      line_done;

  ppu_regs_t regs;

  // Fetcher to VRAM
  bus_addr_t fetch_addr;
  byte_t     fetch_data;

  // Fetcher to FIFO to writer
  logic             push;
  color_idx_t [7:0] push_row;
  logic             pop;
  color_idx_t       fifo_head;
  logic [4:0]       fifo_count;

  ppu_timing #(
    .dots_per_line  (dots_per_line),
    .lines_per_frame(lines_per_frame),
    .screen_height  (screen_height),
    .mode2_len      (mode2_len)
  ) timing0 (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .line_done (line_done),
    .mode      (mode),
    .ly        (ly),
    .dot       (),
    .flush     (flush),
    .vblank_req(vblank_req),
    .stat_req  (stat_req),
    .lyc_match (lyc_match)
  );

  ppu_mem_bus mem_bus0 (
    .clk       (clk),
    .reset     (reset),
    .host      (host),
    .host_rdata(host_rdata),
    .mode      (mode),
    .ly        (ly),
    .lyc_match (lyc_match),
    .regs      (regs),
    .fetch_addr(fetch_addr),
    .fetch_data(fetch_data)
  );

  bg_fetcher fetcher0 (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .ly        (ly),
    .flush     (flush),
    .mode      (mode),
    .fifo_count(fifo_count),
    .fetch_addr(fetch_addr),
    .fetch_data(fetch_data),
    .push      (push),
    .push_row  (push_row)
  );

  pixel_fifo fifo0 (
    .clk     (clk),
    .reset   (reset),
    .flush   (flush),
    .push    (push),
    .push_row(push_row),
    .pop     (pop),
    .head    (fifo_head),
    .count   (fifo_count)
  );

  line_writer #(
    .screen_width(screen_width)
  ) writer0 (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .regs       (regs),
    .ly         (ly),
    .flush      (flush),
    .fifo_head  (fifo_head),
    .fifo_count (fifo_count),
    .pop        (pop),
    .pixel_valid(pixel_valid),
    .pixel      (pixel),
    .line_done  (line_done)
  );

endmodule

// ==== sim/ppu_tb.sv ====
`timescale 1ns/1ps

module ppu_tb;

  import ppu_pkg::*;

  // Small frame for simulation
  localparam int screen_width = 16;
  localparam int screen_height = 4;
  localparam int lines_per_frame = 6;
  localparam int mode2_len = 20;
  localparam int dots_per_line = 120;

  localparam int frame_cycles = dots_per_line * lines_per_frame;
  localparam int frame_pixels = screen_width * screen_height;
  localparam int num_tests = 6;
  // VRAM fill, map refill, OAM traffic, slack
  localparam int setup_cycles = vram_words + 2048 + 2 * oam_words + 1024;
  localparam int timeout_cycles = num_tests * 4 * frame_cycles + setup_cycles;

  logic       clk;
  logic       reset;
  host_req_t  host;
  byte_t      host_rdata;
  logic       pixel_valid;
  pixel_t     pix;
  logic       vblank_req;
  logic       stat_req;

  // Shadow copies of the host-visible state
  byte_t vram_model [vram_words];
  byte_t oam_model [oam_words];
  byte_t reg_model [16];

  // Run bookkeeping
  string cur_test;
  int    errors;
  int    test_errors0;
  int    tests_run;
  int    tests_failed;
  int    cycle_count;

  // Monitor state
  int   exp_x;
  int   exp_y;
  int   frame_pix;
  int   pix_total;
  int   vblank_count;
  int   stat_count;
  logic line_complete;
  logic hblank_check;

  ppu_top #(
    .dots_per_line  (dots_per_line),
    .lines_per_frame(lines_per_frame),
    .screen_height  (screen_height),
    .screen_width   (screen_width),
    .mode2_len      (mode2_len)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .host       (host),
    .host_rdata (host_rdata),
    .pixel_valid(pixel_valid),
    .pixel      (pix),
    .vblank_req (vblank_req),
    .stat_req   (stat_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
  end

  // ========================================
  // Reference model
  // ========================================

  // Shade of screen pixel (x, y) from the fetch and palette rules
  function automatic shade_t model_shade(input int x, input int y);
    int    bx;
    int    by;
    int    map_off;
    int    tile;
    int    tile_off;
    int    bit_pos;
    int    idx;
    byte_t lo;
    byte_t hi;
    byte_t lcdc;
    byte_t bgp;
    lcdc = reg_model[lcdc_addr[3:0]];
    bgp = reg_model[bgp_addr[3:0]];
    bx = (reg_model[scx_addr[3:0]] + x) % 256;
    by = (reg_model[scy_addr[3:0]] + y) % 256;
    // Map at 9800h or 9C00h, 32 tiles per row
    map_off = (lcdc[3] ? 'h1C00 : 'h1800) + (by / 8) * 32 + bx / 8;
    tile = vram_model[map_off];
    if (lcdc[4]) begin
      tile_off = tile * 16;
    end else begin
      // Signed tile number around 9000h
      tile_off = 'h1000 + (tile < 128 ? tile : tile - 256) * 16;
    end
    lo = vram_model[tile_off + (by % 8) * 2];
    hi = vram_model[tile_off + (by % 8) * 2 + 1];
    bit_pos = 7 - bx % 8;
    idx = hi[bit_pos] * 2 + lo[bit_pos];
    return bgp[2 * idx +: 2];
  endfunction

  // Register read value while the LCD is off
  function automatic byte_t expected_reg(input bus_addr_t a);
    case (a)
      stat_addr: begin
        return {1'b1, reg_model[1][6:3], reg_model[5] == 8'h00, 2'b10};
      end
      ly_addr: return 8'h00;
      lcdc_addr, scy_addr, scx_addr, lyc_addr, bgp_addr, wy_addr, wx_addr: begin
        return reg_model[a[3:0]];
      end
      default: return 8'hFF;
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // ========================================
  // Host bus
  // ========================================

  task automatic host_write(input bus_addr_t a, input byte_t d);
    @(negedge clk);
    host.addr     = a;
    host.wdata    = d;
    host.write_en = 1'b1;
    host.read_en  = 1'b0;
    if (a inside {[vram_start : vram_end]}) begin
      vram_model[a - vram_start] = d;
    end else if (a inside {[oam_start : oam_end]}) begin
      oam_model[a - oam_start] = d;
    end else if (a inside {[regs_start : regs_end]} && a != ly_addr && a != dma_addr) begin
      reg_model[a[3:0]] = d;
    end
    @(posedge clk);
  endtask

  // Read data sampled mid-cycle, after the decode settles
  task automatic host_read(input bus_addr_t a, output byte_t d);
    @(negedge clk);
    host.addr     = a;
    host.write_en = 1'b0;
    host.read_en  = 1'b1;
    #2;
    d = host_rdata;
  endtask

  task automatic host_idle();
    @(negedge clk);
    host.write_en = 1'b0;
    host.read_en  = 1'b0;
  endtask

  task automatic run_cycles(input int n);
    host_idle();
    repeat (n) @(negedge clk);
  endtask

  task automatic lcd_on(input byte_t v);
    // Frame restarts at line 0
    exp_x = 0;
    exp_y = 0;
    frame_pix = 0;
    line_complete = 1'b0;
    host_write(lcdc_addr, v | 8'h80);
  endtask

  task automatic lcd_off();
    host_write(lcdc_addr, reg_model[0] & 8'h7F);
    run_cycles(4);
  endtask

  task automatic wait_vblanks(input int n);
    int target;
    target = vblank_count + n;
    host_idle();
    wait (vblank_count >= target);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_errors0) begin
      tests_failed++;
    end
    $display("test %-8s %s", cur_test, errors == test_errors0 ? "ok" : "FAIL");
  endtask

  // ========================================
  // Output monitor
  // ========================================

  always @(negedge clk) begin
    if (!reset) begin
      if (pixel_valid) begin
        check("pixel x", exp_x, pix.x);
        check("pixel y", exp_y, pix.y);
        check("shade", model_shade(exp_x, exp_y), pix.shade);
        pix_total++;
        frame_pix++;
        line_complete = 1'b0;
        exp_x++;
        if (exp_x == screen_width) begin
          exp_x = 0;
          exp_y = (exp_y + 1) % screen_height;
          line_complete = 1'b1;
        end
      end
      if (vblank_req) begin
        vblank_count++;
        // Whole frame out before the pulse
        assert (frame_pix == frame_pixels) else begin
          $display("%s: vblank_req came after %0d pixels of the frame, not %0d",
                   cur_test, frame_pix, frame_pixels);
          errors++;
        end
        frame_pix = 0;
      end
      if (stat_req) begin
        stat_count++;
        if (hblank_check) begin
          assert (line_complete) else begin
            $display("%s: stat_req came before the line's last pixel", cur_test);
            errors++;
          end
          line_complete = 1'b0;
        end
      end
    end
  end

  // ========================================
  // Tests
  // ========================================

  initial begin
    byte_t     d;
    bus_addr_t a;
    int        hits;
    int        n0;
    int        v0;
    int        s0;
    void'($urandom(32'h3f6eec39));
    reset = 1'b1;
    host = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    exp_x = 0;
    exp_y = 0;
    frame_pix = 0;
    pix_total = 0;
    vblank_count = 0;
    stat_count = 0;
    line_complete = 1'b0;
    hblank_check = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Register file with the LCD off
    start_test("regs");
    for (int i = 0; i < 12; i++) begin
      a = regs_start + bus_addr_t'(i);
      host_write(a, a == lcdc_addr ? byte_t'($urandom) & 8'h7F : byte_t'($urandom));
    end
    run_cycles(2);
    for (int i = 0; i < 16; i++) begin
      a = regs_start + bus_addr_t'(i);
      host_read(a, d);
      check($sformatf("reg %0h", a), expected_reg(a), d);
    end
    end_test();

    // VRAM and OAM, then the VRAM lock in transfer
    start_test("memory");
    for (int i = 0; i < vram_words; i++) begin
      host_write(vram_start + bus_addr_t'(i), byte_t'($urandom));
    end
    for (int i = 0; i < 64; i++) begin
      a = vram_start + bus_addr_t'($urandom % vram_words);
      host_read(a, d);
      check("vram", vram_model[a - vram_start], d);
    end
    for (int i = 0; i < oam_words; i++) begin
      host_write(oam_start + bus_addr_t'(i), byte_t'($urandom));
    end
    for (int i = 0; i < oam_words; i++) begin
      host_read(oam_start + bus_addr_t'(i), d);
      check("oam", oam_model[i], d);
    end
    lcd_on(reg_model[0]);
    hits = 0;
    for (int i = 0; i < frame_cycles / 2; i++) begin
      host_read(vram_start + bus_addr_t'($urandom % vram_words), d);
      if (pixel_valid) begin
        check("vram locked", 8'hFF, d);
        hits++;
      end
      a = oam_start + bus_addr_t'($urandom % oam_words);
      host_read(a, d);
      check("oam lcd on", oam_model[a - oam_start], d);
    end
    assert (hits > 0) else begin
      $display("%s: no VRAM read landed during pixel output", cur_test);
      errors++;
    end
    lcd_off();
    end_test();

    // Background pixels, every map and tile data select
    start_test("pixels");
    for (int i = 'h1800; i < 'h2000; i++) begin
      host_write(vram_start + bus_addr_t'(i), byte_t'($urandom));
    end
    host_write(stat_addr, 8'h00);
    n0 = pix_total;
    for (int c = 0; c < 4; c++) begin
      host_write(scx_addr, byte_t'($urandom));
      host_write(scy_addr, byte_t'($urandom));
      host_write(bgp_addr, byte_t'($urandom));
      lcd_on({3'b000, c[1], c[0], 3'b000});
      wait_vblanks(1);
      lcd_off();
    end
    check("pixel count", 4 * frame_pixels, pix_total - n0);
    end_test();

    // One VBlank per frame
    start_test("vblank");
    lcd_on(reg_model[0]);
    v0 = vblank_count;
    run_cycles(2 * frame_cycles);
    check("vblank count", 2, vblank_count - v0);
    lcd_off();
    end_test();

    // LYC source, then the HBlank source
    start_test("stat");
    host_write(lyc_addr, 8'd2);
    host_write(stat_addr, 8'h40);
    lcd_on(reg_model[0]);
    s0 = stat_count;
    run_cycles(2 * frame_cycles);
    check("lyc pulses", 2, stat_count - s0);
    lcd_off();
    host_write(stat_addr, 8'h08);
    hblank_check = 1'b1;
    lcd_on(reg_model[0]);
    s0 = stat_count;
    run_cycles(2 * frame_cycles);
    check("hblank pulses", 2 * screen_height, stat_count - s0);
    hblank_check = 1'b0;
    lcd_off();
    end_test();

    // LCD switched off in the middle of line 2
    start_test("disable");
    host_write(stat_addr, 8'h48);
    lcd_on(reg_model[0]);
    wait (exp_y == 2 && exp_x >= 5);
    lcd_off();
    n0 = pix_total;
    v0 = vblank_count;
    s0 = stat_count;
    run_cycles(2 * frame_cycles);
    check("pixels off", 0, pix_total - n0);
    check("vblank off", 0, vblank_count - v0);
    check("stat off", 0, stat_count - s0);
    host_read(ly_addr, d);
    check("ly", 8'h00, d);
    host_read(stat_addr, d);
    check("stat mode", 2'b10, d[1:0]);
    host_idle();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    wait (cycle_count >= timeout_cycles);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== sim.f ====
common/ppu_pkg.sv
ppu/ppu_timing.sv
ppu/ppu_mem_bus.sv
ppu/bg_fetcher.sv
ppu/pixel_fifo.sv
ppu/line_writer.sv
src/ppu_top.sv
sim/ppu_tb.sv

// ==== Bender.yml ====
package:
  name: ppu

sources:
  - common/ppu_pkg.sv
  - ppu/ppu_timing.sv
  - ppu/ppu_mem_bus.sv
  - ppu/bg_fetcher.sv
  - ppu/pixel_fifo.sv
  - ppu/line_writer.sv
  - src/ppu_top.sv
  - target: test
    files:
      - sim/ppu_tb.sv
